// ==== hw/zx_ports_macros.svh ====
// port address codes, BF reset value and BE read-back selector codes
// shared by the decoder, the read mux and the testbench

`ifndef ZX_PORTS_MACROS_SVH
`define ZX_PORTS_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// low address byte of each kept port

`define ZX_PORT_FE      8'hFE   // border, beeper, keyboard
`define ZX_PORT_F6      8'hF6   // FE alias
`define ZX_PORT_FD      8'hFD   // 7FFD paging, AY BFFD/FFFD
`define ZX_PORT_F7      8'hF7   // EFF7 paging
`define ZX_PORT_KJOY    8'h1F   // kempston joystick
`define ZX_PORT_KMOUSE  8'hDF   // kempston mouse
`define ZX_PORT_SDCFG   8'h77   // z-controller config
`define ZX_PORT_SDDAT   8'h57   // z-controller spi data
`define ZX_PORT_CFG_BF  8'hBF   // shadow, rom write, font write
`define ZX_PORT_CFG_BE  8'hBE   // config read-back

////////////////////////////////////////////////////////////////////////////
// read and reset values

// pulled-up bus, what an unmatched port reads
`define ZX_RD_IDLE      8'hFF

// BF bits after reset, all features off
`define ZX_CFG_RST      3'b000

////////////////////////////////////////////////////////////////////////////
// BE selector in a[11:8]

`define ZX_BE_SEL_7FFD  4'hA
`define ZX_BE_SEL_EFF7  4'hB

`endif

// ==== hw/zx_port_pkg.sv ====
// types for the Z80 I/O bus side
// data byte, port select byte and full address

package zx_port_pkg;

	// one byte on the z80 data bus
	typedef logic [7:0] io_byte_t;

	// low address byte, selects the port
	typedef logic [7:0] port_lo_t;

	// full z80 address, upper byte
	// qualifies some ports (7FFD, EFF7, AY, BE)
	typedef logic [15:0] io_addr_t;

endpackage

// ==== hw/zx_mem_pkg.sv ====
// types for paging and border state

package zx_mem_pkg;

	// pentagon-1M ram page, 64 pages of 16k
	typedef logic [5:0] page_t;

	// border colour grb plus bright in bit 3
	typedef logic [3:0] border_t;

	// image of a paging register (7FFD or EFF7)
	typedef logic [7:0] page_reg_t;

endpackage

// ==== hw/zx_io_ctrl.sv ====
// Z80 I/O cycle edge detect, port decode under shadow rules
// BF configuration register, hit flags and per-port write strobes

`timescale 1ns/100ps
`include "zx_ports_macros.svh"

module zx_io_ctrl (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zx_port_pkg::io_addr_t a,
	input  zx_port_pkg::io_byte_t din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  dos,            // dos rom paged in
	output logic                  porthit,        // internal port, blocks zxbus iorq
	output logic                  external_port,  // AY data/reg port
	output logic                  dataout,        // drive z80 bus
	output logic                  shadow,
	output logic                  cfg_romrw,
	output logic                  cfg_fntw,
	output logic                  cfg_shadow_en,
	output logic                  p7ffd_wr,
	output logic                  peff7_wr,
	output logic                  fe_wr,
	output logic                  beeper_wr,
	output logic                  sdcfg_wr,
	output logic                  sddat_acc
);

	zx_port_pkg::port_lo_t loa;
	logic                  iowr_now;  // io write cycle in progress
	logic                  iord_now;
	logic                  iowr_q;
	logic                  iord_q;
	logic                  port_wr;   // one zclk per io write
	logic                  port_rd;
	logic [2:0]            cfg_q;     // fntw, romrw, shadow_en

	assign loa      = a[7:0];
	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	////////////////////////////////////////////////////////////////////////////
	// cycle strobes, rising edge of the active cycle

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q  <= 1'b0;
			iord_q  <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			iowr_q  <= iowr_now;
			iord_q  <= iord_now;
			port_wr <= iowr_now & ~iowr_q;  // first sample only
			port_rd <= iord_now & ~iord_q;
		end
	end

	// BF config port
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			cfg_q <= `ZX_CFG_RST;
		else if (port_wr && loa == `ZX_PORT_CFG_BF)
			cfg_q <= din[2:0];
	end

	assign cfg_shadow_en = cfg_q[0];
	assign cfg_romrw     = cfg_q[1];
	assign cfg_fntw      = cfg_q[2];
	assign shadow        = dos | cfg_shadow_en;

	////////////////////////////////////////////////////////////////////////////
	// hit flags

	always_comb
	begin
		case (loa)
			`ZX_PORT_FE, `ZX_PORT_F6, `ZX_PORT_FD, `ZX_PORT_KMOUSE,
			`ZX_PORT_SDDAT, `ZX_PORT_CFG_BF, `ZX_PORT_CFG_BE:
				porthit = 1'b1;
			// hidden while shadow is on
			`ZX_PORT_KJOY, `ZX_PORT_F7, `ZX_PORT_SDCFG:
				porthit = ~shadow;
			default:
				porthit = 1'b0;
		endcase
	end

	assign external_port = (loa == `ZX_PORT_FD) && (a[15:14] == 2'b11);  // FFFD only
	assign dataout       = porthit & iord_now & ~external_port;

	// write strobes, one per cycle
	assign p7ffd_wr  = port_wr && loa == `ZX_PORT_FD && !a[15];
	assign peff7_wr  = port_wr && loa == `ZX_PORT_F7 && a[8] && !a[12] && !shadow;
	assign fe_wr     = port_wr && (loa == `ZX_PORT_FE || loa == `ZX_PORT_F6);
	assign beeper_wr = port_wr && loa == `ZX_PORT_FE;   // not on the F6 alias

	// z-controller, 57 with a15 set is the cfg port in shadow
	assign sdcfg_wr  = port_wr && ((loa == `ZX_PORT_SDCFG && !shadow) ||
	                               (loa == `ZX_PORT_SDDAT && shadow && a[15]));
	assign sddat_acc = loa == `ZX_PORT_SDDAT &&
	                   (port_rd || (port_wr && (!shadow || !a[15])));

endmodule

// ==== hw/zx_paging_regs.sv ====
// 7FFD and EFF7 paging registers with the 1M lock
// rom bit seeded from rom_sel after reset, pentagon-1M page outputs

`timescale 1ns/100ps

module zx_paging_regs (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  zx_port_pkg::io_byte_t  din,
	input  logic                   rom_sel,     // rom chosen at power-up
	input  logic                   p7ffd_wr,
	input  logic                   peff7_wr,
	output zx_mem_pkg::page_reg_t  p7ffd,
	output zx_mem_pkg::page_reg_t  peff7,
	output zx_mem_pkg::page_reg_t  p7ffd_raw,   // for BE read-back
	output zx_mem_pkg::page_reg_t  peff7_raw,
	output zx_mem_pkg::page_t      pent1m_page,
	output logic                   pent1m_rom,
	output logic                   pent1m_1m_on,
	output logic                   pent1m_ram0_0
);

	zx_mem_pkg::page_reg_t p7ffd_q;
	zx_mem_pkg::page_reg_t peff7_q;
	logic                  p7ffd_rom;   // rom bit as seen by the pager
	logic [1:0]            rst_sync;    // held high through reset
	logic                  block1m;
	logic                  block7ffd;

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q[5] & block1m;  // 48k lock only in 128k mode

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rst_sync <= 2'b11;
		else
			rst_sync <= {rst_sync[0], 1'b0};
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
			peff7_q <= '0;
		end
		else
		begin
			if (p7ffd_wr && !block7ffd)
				p7ffd_q <= din;   // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 hi page
			if (peff7_wr)
				peff7_q <= din;   // 0 p16c, 2 128k mode, 3 ram0, 4 turbo off
		end
	end

	// rom bit follows rom_sel until the sync drains
	always_ff @(posedge zclk)
	begin
		if (rst_sync[1])
			p7ffd_rom <= rom_sel;
		else if (p7ffd_wr && !block7ffd)
			p7ffd_rom <= din[4];
	end

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_rom, p7ffd_q[3:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]}
	                       : peff7_q;

	assign p7ffd_raw     = p7ffd_q;
	assign peff7_raw     = peff7_q;
	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]};  // full 1M page
	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_1m_on  = ~peff7_q[2];
	assign pent1m_ram0_0 = peff7_q[3];

endmodule

// ==== hw/zx_sd_port.sv ====
// z-controller SD port, chip select, spi start pulse, spi data out

`timescale 1ns/100ps

module zx_sd_port (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zx_port_pkg::io_byte_t din,
	input  logic                  wr_n,
	input  logic                  sdcfg_wr,
	input  logic                  sddat_acc,   // read or write of the data port
	output logic                  sdcs_n,
	output logic                  sd_start,    // one spi byte transfer
	output zx_port_pkg::io_byte_t sd_datain
);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sdcs_n   <= 1'b1;   // card deselected
			sd_start <= 1'b0;
		end
		else
		begin
			if (sdcfg_wr)
				sdcs_n <= din[1];
			sd_start <= sddat_acc;   // strobe already single cycle
		end
	end

	// reads shift out FF so the card sees idle MOSI
	assign sd_datain = wr_n ? 8'hFF : din;

endmodule

// ==== hw/zx_border_ay.sv ====
// border colour register and AY chip bus control

`timescale 1ns/100ps
`include "zx_ports_macros.svh"

module zx_border_ay (
	input  logic                  zclk,
	input  zx_port_pkg::io_addr_t a,
	input  zx_port_pkg::io_byte_t din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  fe_wr,
	output zx_mem_pkg::border_t   border,
	output logic                  ay_bc1,
	output logic                  ay_bdir
);

	logic ay_sel;   // xxFD with a15 set
	logic ay_reg;   // FFFD, register select / read

	// bright is active low on a3
	always_ff @(posedge zclk)
	begin
		if (fe_wr)
			border <= {~a[3], din[2:0]};
	end

	assign ay_sel = (a[7:0] == `ZX_PORT_FD) && a[15];
	assign ay_reg = ay_sel && a[14];

	assign ay_bc1  = ay_reg & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = ay_sel & ~iorq_n & ~wr_n;   // BFFD and FFFD writes

endmodule

// ==== hw/zx_read_mux.sv ====
// Z80 read data selection by low address byte
// includes BF config and BE paging read-back

`timescale 1ns/100ps
`include "zx_ports_macros.svh"

module zx_read_mux (
	input  zx_port_pkg::io_addr_t  a,
	input  logic [4:0]             keys_in,     // keyboard columns, active low
	input  logic                   tape_read,
	input  logic [4:0]             kj_in,       // kempston, active high
	input  zx_port_pkg::io_byte_t  mus_in,
	input  zx_port_pkg::io_byte_t  sd_dataout,
	input  logic                   cfg_shadow_en,
	input  logic                   cfg_romrw,
	input  logic                   cfg_fntw,
	input  zx_mem_pkg::page_reg_t  p7ffd_raw,
	input  zx_mem_pkg::page_reg_t  peff7_raw,
	output zx_port_pkg::io_byte_t  dout
);

	zx_port_pkg::port_lo_t loa;

	assign loa = a[7:0];

	always_comb
	begin
		case (loa)
			`ZX_PORT_FE, `ZX_PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZX_PORT_KJOY:   dout = {3'b000, kj_in};
			`ZX_PORT_KMOUSE: dout = mus_in;
			`ZX_PORT_SDCFG:  dout = 8'h00;       // card present, not protected
			`ZX_PORT_SDDAT:  dout = sd_dataout;  // last spi byte
			`ZX_PORT_CFG_BF: dout = {5'b00000, cfg_fntw, cfg_romrw, cfg_shadow_en};
			`ZX_PORT_CFG_BE:
			begin
				// selector in the high byte
				case (a[11:8])
					`ZX_BE_SEL_7FFD: dout = p7ffd_raw;
					`ZX_BE_SEL_EFF7: dout = peff7_raw;
					default:         dout = `ZX_RD_IDLE;
				endcase
			end
			default:
				dout = `ZX_RD_IDLE;
		endcase
	end

endmodule

// ==== hw/zx_ports.sv ====
// Z80 I/O port block top, decoder plus paging, SD, border/AY and read mux

`timescale 1ns/100ps

module zx_ports (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zx_port_pkg::io_addr_t a,
	input  zx_port_pkg::io_byte_t din,
	output zx_port_pkg::io_byte_t dout,
	output logic                  dataout,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output logic                  porthit,
	output logic                  external_port,
	input  logic                  dos,
	output logic                  shadow,      // to the memory pager
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,
	input  zx_port_pkg::io_byte_t mus_in,
	output zx_mem_pkg::border_t   border,
	output logic                  beeper_wr,
	output logic                  ay_bc1,
	output logic                  ay_bdir,
	input  logic                  rom_sel,
	output zx_mem_pkg::page_reg_t p7ffd,
	output zx_mem_pkg::page_reg_t peff7,
	output zx_mem_pkg::page_t     pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic                  sdcs_n,
	output logic                  sd_start,
	output zx_port_pkg::io_byte_t sd_datain,
	input  zx_port_pkg::io_byte_t sd_dataout,
	output logic                  romrw_en,    // BF bit 1
	output logic                  fntw_en      // BF bit 2
);

	logic                  cfg_shadow_en;
	logic                  p7ffd_wr;
	logic                  peff7_wr;
	logic                  fe_wr;
	logic                  sdcfg_wr;
	logic                  sddat_acc;
	zx_mem_pkg::page_reg_t p7ffd_raw;
	zx_mem_pkg::page_reg_t peff7_raw;

	////////////////////////////////////////////////////////////////////////////
	// decoder, the only place that looks at port addresses for strobes

	zx_io_ctrl u_io_ctrl (
		.zclk(zclk), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .dos(dos),
		.porthit(porthit), .external_port(external_port), .dataout(dataout),
		.shadow(shadow), .cfg_romrw(romrw_en), .cfg_fntw(fntw_en),
		.cfg_shadow_en(cfg_shadow_en), .p7ffd_wr(p7ffd_wr), .peff7_wr(peff7_wr),
		.fe_wr(fe_wr), .beeper_wr(beeper_wr), .sdcfg_wr(sdcfg_wr), .sddat_acc(sddat_acc)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath

	zx_paging_regs u_paging_regs (
		.zclk(zclk), .rst_n(rst_n), .din(din), .rom_sel(rom_sel),
		.p7ffd_wr(p7ffd_wr), .peff7_wr(peff7_wr),
		.p7ffd(p7ffd), .peff7(peff7), .p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0)
	);

	zx_sd_port u_sd_port (
		.zclk(zclk), .rst_n(rst_n), .din(din), .wr_n(wr_n),
		.sdcfg_wr(sdcfg_wr), .sddat_acc(sddat_acc),
		.sdcs_n(sdcs_n), .sd_start(sd_start), .sd_datain(sd_datain)
	);

	zx_border_ay u_border_ay (
		.zclk(zclk), .a(a), .din(din), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.fe_wr(fe_wr), .border(border), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir)
	);

	zx_read_mux u_read_mux (
		.a(a), .keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in),
		.mus_in(mus_in), .sd_dataout(sd_dataout), .cfg_shadow_en(cfg_shadow_en),
		.cfg_romrw(romrw_en), .cfg_fntw(fntw_en),
		.p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw), .dout(dout)
	);

endmodule

// ==== dv/zx_ports_clk.sv ====
// testbench clock, 10 ns period, and active-low reset held for 3 cycles

`timescale 1ns/100ps

module zx_ports_clk (
	output logic zclk,
	output logic rst_n
);

	initial
	begin
		zclk = 1'b0;
		forever #5 zclk = ~zclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge zclk);
		#1 rst_n = 1'b1;   // release just after an edge
	end

endmodule

// ==== dv/zx_ports_tb.sv ====
// testbench for the Z80 I/O port block
// Z80 I/O cycle driver, reference model, output checker and LFSR source

`timescale 1ns/100ps
`include "zx_ports_macros.svh"

module zx_ports_tb;

	logic                  zclk;
	logic                  rst_n;
	zx_port_pkg::io_addr_t a;
	zx_port_pkg::io_byte_t din;
	zx_port_pkg::io_byte_t dout;
	logic                  dataout, iorq_n, rd_n, wr_n, porthit, external_port, dos, shadow;
	logic [4:0]            keys_in;
	logic                  tape_read;
	logic [4:0]            kj_in;
	zx_port_pkg::io_byte_t mus_in;
	zx_mem_pkg::border_t   border;
	logic                  beeper_wr, ay_bc1, ay_bdir, rom_sel;
	zx_mem_pkg::page_reg_t p7ffd;
	zx_mem_pkg::page_reg_t peff7;
	zx_mem_pkg::page_t     pent1m_page;
	logic                  pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic                  sdcs_n, sd_start;
	zx_port_pkg::io_byte_t sd_datain;
	zx_port_pkg::io_byte_t sd_dataout;
	logic                  romrw_en, fntw_en;

	// reference model state
	zx_mem_pkg::page_reg_t m_7ffd;      // raw 7FFD image
	zx_mem_pkg::page_reg_t m_eff7;
	logic                  m_rom;       // rom bit seen by the pager
	logic [2:0]            m_cfg;       // BF bits
	logic                  m_sdcs_n;
	zx_mem_pkg::border_t   m_border;
	logic                  border_known;   // border written at least once

	logic [15:0] lfsr_state;
	logic        busy;        // write in flight so registers may lead the model
	logic        chk_on;
	logic [7:0]  sd_pulses;
	logic [7:0]  beep_pulses;
	int          checks;
	int          errors;

	zx_ports_clk u_clk (.zclk(zclk), .rst_n(rst_n));

	zx_ports u_zx_ports (.*);

	////////////////////////////////////////////////////////////////////////////
	// 16-bit fibonacci lfsr with taps 16 14 13 11

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic shadow_on();
		return dos | m_cfg[0];
	endfunction

	function automatic logic exp_hit(input zx_port_pkg::io_addr_t ad);
		case (ad[7:0])
			`ZX_PORT_FE, `ZX_PORT_F6, `ZX_PORT_FD, `ZX_PORT_KMOUSE,
			`ZX_PORT_SDDAT, `ZX_PORT_CFG_BF, `ZX_PORT_CFG_BE:
				return 1'b1;
			`ZX_PORT_KJOY, `ZX_PORT_F7, `ZX_PORT_SDCFG:
				return !shadow_on();   // hidden in shadow
			default:
				return 1'b0;
		endcase
	endfunction

	// byte the port block returns for a read of this address
	function automatic logic [7:0] exp_read(input zx_port_pkg::io_addr_t ad);
		case (ad[7:0])
			`ZX_PORT_FE, `ZX_PORT_F6: return {1'b1, tape_read, 1'b0, keys_in};
			`ZX_PORT_KJOY:            return {3'b000, kj_in};
			`ZX_PORT_KMOUSE:          return mus_in;
			`ZX_PORT_SDCFG:           return 8'h00;
			`ZX_PORT_SDDAT:           return sd_dataout;
			`ZX_PORT_CFG_BF:          return {5'b00000, m_cfg};
			`ZX_PORT_CFG_BE:
			begin
				if (ad[11:8] == `ZX_BE_SEL_7FFD)
					return m_7ffd;
				else if (ad[11:8] == `ZX_BE_SEL_EFF7)
					return m_eff7;
				return `ZX_RD_IDLE;
			end
			default:                  return `ZX_RD_IDLE;
		endcase
	endfunction

	task automatic model_write(input zx_port_pkg::io_addr_t ad, input logic [7:0] d);
		case (ad[7:0])
			`ZX_PORT_FE, `ZX_PORT_F6:
			begin
				m_border     = {~ad[3], d[2:0]};
				border_known = 1'b1;
			end
			`ZX_PORT_FD:
				if (!ad[15] && !(m_7ffd[5] && m_eff7[2]))   // 1M lock
				begin
					m_7ffd = d;
					m_rom  = d[4];
				end
			`ZX_PORT_F7:
				if (ad[8] && !ad[12] && !shadow_on())
					m_eff7 = d;
			`ZX_PORT_CFG_BF: m_cfg = d[2:0];
			`ZX_PORT_SDCFG:
				if (!shadow_on())
					m_sdcs_n = d[1];
			`ZX_PORT_SDDAT:
				if (shadow_on() && ad[15])   // cfg port alias in shadow
					m_sdcs_n = d[1];
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checker

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// outputs settle half a cycle after the drive edge
	always @(negedge zclk)
	begin : check_outputs
		logic rd_act;
		logic wr_act;
		logic hit;
		logic ext;
		if (rst_n && chk_on)
		begin
			rd_act = !iorq_n && !rd_n;
			wr_act = !iorq_n && !wr_n;
			hit    = exp_hit(a);
			ext    = a[7:0] == `ZX_PORT_FD && a[15:14] == 2'b11;   // FFFD
			compare("porthit", porthit, hit);
			compare("external_port", external_port, ext);
			compare("dataout", dataout, hit && rd_act && !ext);
			if (rd_act)
				compare("dout", dout, exp_read(a));
			compare("sd_datain", sd_datain, wr_act ? din : 8'hFF);
			compare("ay_bc1", ay_bc1, ext && (rd_act || wr_act));
			compare("ay_bdir", ay_bdir, a[7:0] == `ZX_PORT_FD && a[15] && wr_act);
			if (!busy)
			begin
				compare("p7ffd", p7ffd,
				        {(m_eff7[2] ? 3'b000 : m_7ffd[7:5]), m_rom, m_7ffd[3:0]});
				compare("peff7", peff7, m_eff7[2] ?
				        {m_eff7[7], 1'b0, m_eff7[5:4], 3'b000, m_eff7[0]} : m_eff7);
				compare("pent1m_page", {2'b00, pent1m_page},
				        {2'b00, m_7ffd[7:5], m_7ffd[2:0]});
				compare("pent1m_rom", pent1m_rom, m_7ffd[4]);
				compare("pent1m_1m_on", pent1m_1m_on, !m_eff7[2]);
				compare("pent1m_ram0_0", pent1m_ram0_0, m_eff7[3]);
				compare("sdcs_n", sdcs_n, m_sdcs_n);
				compare("shadow", shadow, shadow_on());
				compare("romrw_en", romrw_en, m_cfg[1]);
				compare("fntw_en", fntw_en, m_cfg[2]);
				if (border_known)
					compare("border", {4'h0, border}, {4'h0, m_border});
			end
		end
	end

	// pulse counters cleared by the cycle driver
	always @(negedge zclk)
	begin
		if (rst_n && sd_start)
			sd_pulses++;
		if (rst_n && beeper_wr)
			beep_pulses++;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	// 3 active cycles then 2 idle from 1 ns after an edge
	task automatic io_cycle(input logic is_wr, input zx_port_pkg::io_addr_t ad,
	                        input logic [7:0] d);
		logic exp_sd;
		exp_sd      = ad[7:0] == `ZX_PORT_SDDAT && (!is_wr || !shadow_on() || !ad[15]);
		sd_pulses   = '0;
		beep_pulses = '0;
		keys_in     = rand_bits(5);
		tape_read   = rand_bits(1);
		kj_in       = rand_bits(5);
		mus_in      = rand_bits(8);
		sd_dataout  = rand_bits(8);
		a           = ad;
		din         = d;
		busy        = is_wr;
		iorq_n      = 1'b0;
		rd_n        = is_wr;
		wr_n        = !is_wr;
		repeat (3)
		begin
			@(posedge zclk);
			#1;
		end
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		if (is_wr)
			model_write(ad, d);
		busy = 1'b0;
		repeat (2)
		begin
			@(posedge zclk);
			#1;
		end
		compare("sd_start pulses", sd_pulses, {7'd0, exp_sd});
		compare("beeper_wr pulses", beep_pulses, {7'd0, is_wr && ad[7:0] == `ZX_PORT_FE});
	endtask

	function automatic zx_port_pkg::io_addr_t rand_port(input logic [3:0] k);
		case (k)
			4'd0:    return 16'h00FE;
			4'd1:    return 16'h00F6;
			4'd2:    return 16'h7FFD;
			4'd3:    return 16'hEFF7;
			4'd4:    return 16'h001F;
			4'd5:    return 16'h00DF;
			4'd6:    return 16'h0077;
			4'd7:    return 16'h0057;
			4'd8:    return 16'h8057;   // sd cfg alias in shadow
			4'd9:    return 16'h00BF;
			4'd10:   return 16'h0ABE;
			4'd11:   return 16'h0BBE;
			4'd12:   return 16'hFFFD;
			4'd13:   return 16'hBFFD;
			4'd14:   return 16'h0012;   // unmatched
			default: return 16'h0CBE;   // bad BE selector
		endcase
	endfunction

	task automatic wait_reset(output logic ok);
		int n;
		n = 0;
		while (!rst_n && n < 20)
		begin
			@(posedge zclk);
			n++;
		end
		#1;
		ok = rst_n;
	endtask

	task automatic run_tests();
		logic [3:0] k;
		repeat (2)
		begin
			@(posedge zclk);
			#1;
		end
		chk_on = 1'b1;
		io_cycle(1'b0, 16'h0ABE, 8'h00);                 // 7FFD raw after reset
		// border, beeper, keyboard
		io_cycle(1'b1, 16'h00FE, rand_bits(8));
		io_cycle(1'b1, 16'h00F6, rand_bits(8));          // bright set, no beeper
		io_cycle(1'b0, 16'h00FE, 8'h00);
		io_cycle(1'b0, 16'h00F6, 8'h00);
		// paging and the 1M lock
		io_cycle(1'b1, 16'h7FFD, rand_bits(8) & 8'hDF);
		io_cycle(1'b1, 16'hEFF7, rand_bits(8) | 8'h04);
		io_cycle(1'b1, 16'h7FFD, rand_bits(8) | 8'h20);  // accepted and sets the lock
		io_cycle(1'b1, 16'h7FFD, rand_bits(8));          // ignored
		io_cycle(1'b0, 16'h0ABE, 8'h00);
		io_cycle(1'b0, 16'h0BBE, 8'h00);
		io_cycle(1'b0, 16'h0CBE, 8'h00);
		// shadow via BF
		io_cycle(1'b0, 16'h001F, 8'h00);
		dos = 1'b1;                                      // dos rom hides 1F too
		io_cycle(1'b0, 16'h001F, 8'h00);
		dos = 1'b0;
		io_cycle(1'b1, 16'h00BF, rand_bits(8) | 8'h01);
		io_cycle(1'b0, 16'h001F, 8'h00);                 // not hit now
		io_cycle(1'b1, 16'hEFF7, rand_bits(8));          // ignored in shadow
		io_cycle(1'b0, 16'h0BBE, 8'h00);
		io_cycle(1'b0, 16'h00BF, 8'h00);
		io_cycle(1'b1, 16'h00BF, 8'h06);
		// z-controller
		io_cycle(1'b1, 16'h0077, 8'h00);
		io_cycle(1'b1, 16'h0077, 8'h02);
		io_cycle(1'b1, 16'h0057, rand_bits(8));
		io_cycle(1'b0, 16'h0057, 8'h00);
		io_cycle(1'b0, 16'h0077, 8'h00);
		// AY and flags
		io_cycle(1'b0, 16'hFFFD, 8'h00);
		io_cycle(1'b1, 16'hFFFD, rand_bits(8));
		io_cycle(1'b1, 16'hBFFD, rand_bits(8));
		io_cycle(1'b0, 16'h00DF, 8'h00);
		// mixed traffic
		repeat (40)
		begin
			k = rand_bits(4);
			io_cycle(rand_bits(1), rand_port(k), rand_bits(8));
		end
	endtask

	initial
	begin
		logic ok;
		a            = '0;
		din          = '0;
		iorq_n       = 1'b1;
		rd_n         = 1'b1;
		wr_n         = 1'b1;
		dos          = 1'b0;
		keys_in      = 5'h1F;
		tape_read    = 1'b0;
		kj_in        = '0;
		mus_in       = '0;
		sd_dataout   = '0;
		rom_sel      = 1'b1;   // rom bit must come up set
		lfsr_state   = 16'd80;
		m_7ffd       = '0;
		m_eff7       = '0;
		m_rom        = 1'b1;
		m_cfg        = '0;
		m_sdcs_n     = 1'b1;
		m_border     = '0;
		border_known = 1'b0;
		busy         = 1'b0;
		chk_on       = 1'b0;
		sd_pulses    = '0;
		beep_pulses  = '0;
		checks       = 0;
		errors       = 0;
		wait_reset(ok);
		if (!ok)
		begin
			$display("timeout, reset was never released");
			$display("ERRORS FOUND");
			$finish;
		end
		else
		begin
			run_tests();
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// ==== zx_ports.f ====
+incdir+hw
hw/zx_port_pkg.sv
hw/zx_mem_pkg.sv
hw/zx_io_ctrl.sv
hw/zx_paging_regs.sv
hw/zx_sd_port.sv
hw/zx_border_ay.sv
hw/zx_read_mux.sv
hw/zx_ports.sv
dv/zx_ports_clk.sv
dv/zx_ports_tb.sv

// ==== Bender.yml ====
package:
  name: zx_ports

sources:
  - include_dirs:
      - hw
    files:
      - hw/zx_port_pkg.sv
      - hw/zx_mem_pkg.sv
      - hw/zx_io_ctrl.sv
      - hw/zx_paging_regs.sv
      - hw/zx_sd_port.sv
      - hw/zx_border_ay.sv
      - hw/zx_read_mux.sv
      - hw/zx_ports.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/zx_ports_clk.sv
      - dv/zx_ports_tb.sv
